// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Line geometry

    localparam int FETCH_WIDTH = 4;     // Words per line
    localparam int LINE_BYTES  = 16;

    ////////////////////////////////////////////////////////////
    // Address and data types

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] inst_t;

    // Word 0 sits in the low bits
    typedef inst_t [FETCH_WIDTH-1:0] line_t;

    typedef logic [FETCH_WIDTH-1:0] enable_t;
    typedef logic [2:0]  inst_num_t;        // 0 to 4 words
    typedef logic [7:0]  cache_index_t;     // vaddr[11:4]
    typedef logic [19:0] cache_tag_t;       // vaddr[31:12]
    typedef logic [4:0]  exc_code_t;

    localparam exc_code_t EXC_ADEL     = 5'd4;    // Address error on fetch
    localparam vaddr_t    RESET_VECTOR = 32'hbfc0_0000;

    ////////////////////////////////////////////////////////////
    // PC register FSM

    typedef enum logic {
        FETCH,
        HALT
    } fetch_state_t;

endpackage

// ==== rtl/pc_register.sv ====
`timescale 1ns/1ns

module pc_register (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stop_fetch_i,
    input  logic                    flush_i,
    input  fetch_pkg::vaddr_t       flush_target_i,
    input  logic                    exc_occur_i,
    input  fetch_pkg::vaddr_t       exc_target_i,
    input  logic                    inst_index_ok_i,
    input  logic                    trace_full_i,
    output logic                    inst_req_o,
    output fetch_pkg::cache_index_t inst_index_o,
    output fetch_pkg::cache_tag_t   inst_tag_o,
    output logic                    push_o,
    output fetch_pkg::vaddr_t       push_vaddr_o,
    output logic                    push_is_exc_o
);

    import fetch_pkg::*;

    vaddr_t       pc_q;
    vaddr_t       pc_d;
    vaddr_t       line_next;
    fetch_state_t state_q;
    fetch_state_t state_d;
    logic         redirect;
    logic         misaligned;
    logic         issue_ok;
    logic         accept;

    assign redirect   = flush_i | exc_occur_i;
    assign misaligned = pc_q[1:0] != 2'b00;

    // Nothing leaves while halted, stalled, full or redirecting
    assign issue_ok = (state_q == FETCH) && !stop_fetch_i && !trace_full_i && !redirect;
    assign accept   = inst_req_o && inst_index_ok_i;

    assign line_next = (pc_q & ~vaddr_t'(LINE_BYTES - 1)) + vaddr_t'(LINE_BYTES);

    ////////////////////////////////////////////////////////////
    // Cache request and trace push

    assign inst_req_o   = issue_ok && !misaligned;
    assign inst_index_o = pc_q[11:4];
    assign inst_tag_o   = pc_q[31:12];

    assign push_o        = accept || (issue_ok && misaligned);   // Bad PC records an exception
    assign push_vaddr_o  = pc_q;
    assign push_is_exc_o = misaligned;

    ////////////////////////////////////////////////////////////
    // Next PC and state

    always_comb begin
        pc_d    = pc_q;
        state_d = state_q;
        if (exc_occur_i) begin
            pc_d    = exc_target_i;     // Exception beats flush
            state_d = FETCH;
        end else if (flush_i) begin
            pc_d    = flush_target_i;
            state_d = FETCH;
        end else if (accept) begin
            pc_d = line_next;
        end else if (issue_ok && misaligned) begin
            state_d = HALT;             // Wait for the next redirect
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_VECTOR;
            state_q <= FETCH;
        end else begin
            pc_q    <= pc_d;
            state_q <= state_d;
        end
    end

    // A waiting request keeps its address until the cache takes it
    assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_req_o && !inst_index_ok_i |=> $stable(inst_index_o) && $stable(inst_tag_o))
        else $error("fetch address changed while request pending");

endmodule

// ==== rtl/first_cache_trace.sv ====
`timescale 1ns/1ns

module first_cache_trace #(
    parameter int OUTSTANDING = 2
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              push_i,
    input  fetch_pkg::vaddr_t push_vaddr_i,
    input  logic              push_is_exc_i,
    input  logic              pop_i,
    input  logic              cancel_i,
    output logic              full_o,
    output logic              head_valid_o,
    output fetch_pkg::vaddr_t head_vaddr_o,
    output logic              head_is_exc_o,
    output logic              head_canceled_o
);

    import fetch_pkg::*;

    localparam int PTR_W = (OUTSTANDING > 1) ? $clog2(OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(OUTSTANDING + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    vaddr_t                 vaddr_q [OUTSTANDING];
    logic [OUTSTANDING-1:0] is_exc_q;
    logic [OUTSTANDING-1:0] canceled_q;
    ptr_t                   wr_ptr_q;
    ptr_t                   rd_ptr_q;
    ptr_t                   tail_ptr;
    cnt_t                   count_q;
    logic                   push_en;
    logic                   pop_en;
    logic                   drop_tail;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(OUTSTANDING - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic ptr_t ptr_dec(ptr_t p);
        return (p == '0) ? ptr_t'(OUTSTANDING - 1) : p - 1'b1;
    endfunction

    assign full_o       = count_q == cnt_t'(OUTSTANDING);
    assign head_valid_o = count_q != '0;
    assign tail_ptr     = ptr_dec(wr_ptr_q);

    assign push_en = push_i && !cancel_i && !full_o;   // Redirect drops the push
    assign pop_en  = pop_i && head_valid_o;

    // An exception record is always the youngest one and never waits for
    // data, so on a redirect it is removed instead of left for the head
    assign drop_tail = cancel_i && is_exc_q[tail_ptr] && (count_q > cnt_t'(pop_en));

    assign head_vaddr_o    = vaddr_q[rd_ptr_q];
    assign head_is_exc_o   = is_exc_q[rd_ptr_q];
    assign head_canceled_o = canceled_q[rd_ptr_q] | cancel_i;

    ////////////////////////////////////////////////////////////
    // Pointers, count and cancel bits

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            canceled_q <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end else if (drop_tail) begin
                wr_ptr_q <= tail_ptr;
            end
            if (pop_en) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + cnt_t'(push_en) - cnt_t'(pop_en) - cnt_t'(drop_tail);
            if (cancel_i) begin
                canceled_q <= '1;                   // Everything in flight is stale
            end else if (push_en) begin
                canceled_q[wr_ptr_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            vaddr_q[wr_ptr_q]  <= push_vaddr_i;
            is_exc_q[wr_ptr_q] <= push_is_exc_i;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) push_i |-> !full_o)
        else $error("push into a full fetch trace");

    assert property (@(posedge clk) disable iff (!rst_n_i) pop_i |-> head_valid_o)
        else $error("pop from an empty fetch trace");

endmodule

// ==== rtl/second_cache_trace.sv ====
`timescale 1ns/1ns

module second_cache_trace (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 inst_data_ok_i,
    input  fetch_pkg::line_t     inst_rdata_i,
    input  logic                 head_valid_i,
    input  fetch_pkg::vaddr_t    head_vaddr_i,
    input  logic                 head_is_exc_i,
    input  logic                 head_canceled_i,
    output logic                 pop_o,
    output logic                 if_valid_o,
    output fetch_pkg::vaddr_t    if_inst_base_pc_o,
    output fetch_pkg::enable_t   if_inst_enable_o,
    output fetch_pkg::line_t     if_inst_o,
    output fetch_pkg::inst_num_t if_inst_num_o,
    output logic                 if_has_exception_o,
    output fetch_pkg::exc_code_t if_exc_code_o
);

    import fetch_pkg::*;

    logic [1:0] word_off;
    logic       take;

    assign word_off = head_vaddr_i[3:2];   // First word the fetch wants

    // Exception records need no data and leave at once
    assign pop_o = head_valid_i && (head_is_exc_i || inst_data_ok_i);
    assign take  = pop_o && !head_canceled_i;

    ////////////////////////////////////////////////////////////
    // Packet to the instruction queue

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            if_valid_o         <= 1'b0;
            if_has_exception_o <= 1'b0;
        end else begin
            if_valid_o         <= take;
            if_has_exception_o <= take && head_is_exc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if_inst_base_pc_o <= head_vaddr_i;
            if_inst_enable_o  <= enable_t'({FETCH_WIDTH{1'b1}} << word_off);
            if_inst_num_o     <= inst_num_t'(FETCH_WIDTH) - inst_num_t'(word_off);
            if_inst_o         <= head_is_exc_i ? '0 : inst_rdata_i;
            if_exc_code_o     <= head_is_exc_i ? EXC_ADEL : exc_code_t'(0);
        end
    end

    // Every cache return must match a request record at the head
    assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_data_ok_i |-> head_valid_i && !head_is_exc_i)
        else $error("cache data returned with no request waiting");

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
    parameter int OUTSTANDING = 2
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stop_fetch_i,
    input  logic                    flush_i,
    input  fetch_pkg::vaddr_t       flush_target_i,
    input  logic                    exc_occur_i,
    input  fetch_pkg::vaddr_t       exc_target_i,
    input  logic                    inst_index_ok_i,
    input  logic                    inst_data_ok_i,
    input  fetch_pkg::line_t        inst_rdata_i,
    output logic                    inst_req_o,
    output fetch_pkg::cache_index_t inst_index_o,
    output fetch_pkg::cache_tag_t   inst_tag_o,
    output logic                    if_valid_o,
    output fetch_pkg::vaddr_t       if_inst_base_pc_o,
    output fetch_pkg::enable_t      if_inst_enable_o,
    output fetch_pkg::line_t        if_inst_o,
    output fetch_pkg::inst_num_t    if_inst_num_o,
    output logic                    if_has_exception_o,
    output fetch_pkg::exc_code_t    if_exc_code_o
);

    import fetch_pkg::*;

    logic   push;
    vaddr_t push_vaddr;
    logic   push_is_exc;
    logic   trace_full;
    logic   head_valid;
    vaddr_t head_vaddr;
    logic   head_is_exc;
    logic   head_canceled;
    logic   pop;
    logic   cancel;

    assign cancel = flush_i | exc_occur_i;   // Either redirect kills in-flight fetches

    pc_register pc_register_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stop_fetch_i    (stop_fetch_i),
        .flush_i         (flush_i),
        .flush_target_i  (flush_target_i),
        .exc_occur_i     (exc_occur_i),
        .exc_target_i    (exc_target_i),
        .inst_index_ok_i (inst_index_ok_i),
        .trace_full_i    (trace_full),
        .inst_req_o      (inst_req_o),
        .inst_index_o    (inst_index_o),
        .inst_tag_o      (inst_tag_o),
        .push_o          (push),
        .push_vaddr_o    (push_vaddr),
        .push_is_exc_o   (push_is_exc)
    );

    first_cache_trace #(
        .OUTSTANDING (OUTSTANDING)
    ) first_cache_trace_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .push_i          (push),
        .push_vaddr_i    (push_vaddr),
        .push_is_exc_i   (push_is_exc),
        .pop_i           (pop),
        .cancel_i        (cancel),
        .full_o          (trace_full),
        .head_valid_o    (head_valid),
        .head_vaddr_o    (head_vaddr),
        .head_is_exc_o   (head_is_exc),
        .head_canceled_o (head_canceled)
    );

    second_cache_trace second_cache_trace_inst (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .inst_data_ok_i     (inst_data_ok_i),
        .inst_rdata_i       (inst_rdata_i),
        .head_valid_i       (head_valid),
        .head_vaddr_i       (head_vaddr),
        .head_is_exc_i      (head_is_exc),
        .head_canceled_i    (head_canceled),
        .pop_o              (pop),
        .if_valid_o         (if_valid_o),
        .if_inst_base_pc_o  (if_inst_base_pc_o),
        .if_inst_enable_o   (if_inst_enable_o),
        .if_inst_o          (if_inst_o),
        .if_inst_num_o      (if_inst_num_o),
        .if_has_exception_o (if_has_exception_o),
        .if_exc_code_o      (if_exc_code_o)
    );

endmodule

// ==== testbench/inst_cache_model.sv ====
`timescale 1ns/1ns

module inst_cache_model (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    inst_req_i,
    input  fetch_pkg::cache_index_t inst_index_i,
    input  fetch_pkg::cache_tag_t   inst_tag_i,
    output logic                    inst_index_ok_o,
    output logic                    inst_data_ok_o,
    output fetch_pkg::line_t        inst_rdata_o
);

    import fetch_pkg::*;

    int     seed = 32'h2eeb_9f3e;
    int     cycle;
    vaddr_t pend_addr [$];      // Line bases still owed, oldest first
    int     pend_due [$];
    logic   index_ok_q = 1'b0;
    logic   data_ok_q  = 1'b0;
    line_t  rdata_q    = '0;

    assign inst_index_ok_o = index_ok_q;
    assign inst_data_ok_o  = data_ok_q;
    assign inst_rdata_o    = rdata_q;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            index_ok_q <= 1'b0;
            data_ok_q  <= 1'b0;
            cycle      <= 0;
            pend_addr.delete();
            pend_due.delete();
        end else begin
            cycle <= cycle + 1;
            if (inst_req_i && index_ok_q) begin
                pend_addr.push_back({inst_tag_i, inst_index_i, 4'b0000});
                pend_due.push_back(cycle + ($random(seed) & 3));   // 1 to 4 cycles
            end
            index_ok_q <= ($random(seed) & 3) != 0;
            data_ok_q  <= 1'b0;
            // Returns stay in order even when a younger one is due earlier
            if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
                data_ok_q <= 1'b1;
                for (int i = 0; i < FETCH_WIDTH; i++) begin
                    rdata_q[i] <= pend_addr[0] + 32'(4 * i);
                end
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

endmodule

// ==== testbench/tb_fetch_unit.sv ====
`timescale 1ns/1ns

module tb_fetch_unit;

    import fetch_pkg::*;

    localparam int OUTSTANDING = 2;
    localparam int WAIT_LIMIT  = 300;

    logic         clk;
    logic         rst_n;
    logic         stop_fetch;
    logic         flush;
    vaddr_t       flush_target;
    logic         exc_occur;
    vaddr_t       exc_target;
    logic         index_ok;
    logic         data_ok;
    line_t        rdata;
    logic         inst_req;
    cache_index_t inst_index;
    cache_tag_t   inst_tag;
    logic         if_valid;
    vaddr_t       if_base_pc;
    enable_t      if_enable;
    line_t        if_inst;
    inst_num_t    if_num;
    logic         if_has_exc;
    exc_code_t    if_exc_code;

    // Reference state
    vaddr_t redirect_target;
    vaddr_t expect_base;
    logic   expect_exc;
    logic   exc_done;
    logic   halted;
    logic   stop_q;
    int     redirect_pkts;
    int     stop_pkts;
    int     err_count;
    int     err_mark;
    int     test_num;

    fetch_unit #(
        .OUTSTANDING (OUTSTANDING)
    ) fetch_unit_inst (
        .clk                (clk),
        .rst_n_i            (rst_n),
        .stop_fetch_i       (stop_fetch),
        .flush_i            (flush),
        .flush_target_i     (flush_target),
        .exc_occur_i        (exc_occur),
        .exc_target_i       (exc_target),
        .inst_index_ok_i    (index_ok),
        .inst_data_ok_i     (data_ok),
        .inst_rdata_i       (rdata),
        .inst_req_o         (inst_req),
        .inst_index_o       (inst_index),
        .inst_tag_o         (inst_tag),
        .if_valid_o         (if_valid),
        .if_inst_base_pc_o  (if_base_pc),
        .if_inst_enable_o   (if_enable),
        .if_inst_o          (if_inst),
        .if_inst_num_o      (if_num),
        .if_has_exception_o (if_has_exc),
        .if_exc_code_o      (if_exc_code)
    );

    inst_cache_model cache_model (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .inst_req_i      (inst_req),
        .inst_index_i    (inst_index),
        .inst_tag_i      (inst_tag),
        .inst_index_ok_o (index_ok),
        .inst_data_ok_o  (data_ok),
        .inst_rdata_o    (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Expected packet contents

    function automatic enable_t enable_for(vaddr_t pc);
        case (pc[3:2])
            2'd0:    return 4'b1111;
            2'd1:    return 4'b1110;
            2'd2:    return 4'b1100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic inst_num_t num_for(vaddr_t pc);
        case (pc[3:2])
            2'd0:    return 3'd4;
            2'd1:    return 3'd3;
            2'd2:    return 3'd2;
            default: return 3'd1;
        endcase
    endfunction

    // Every word holds its own byte address
    function automatic line_t line_for(vaddr_t pc);
        line_t line;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            line[i] = {pc[31:4], 4'b0000} + 32'(4 * i);
        end
        return line;
    endfunction

    assign redirect_target = exc_occur ? exc_target : flush_target;   // Exception wins

    always @(posedge clk) begin
        if (!rst_n) begin
            expect_base   <= RESET_VECTOR;
            expect_exc    <= 1'b0;
            exc_done      <= 1'b0;
            halted        <= 1'b0;
            stop_q        <= 1'b0;
            redirect_pkts <= 0;
            stop_pkts     <= 0;
        end else begin
            stop_q <= stop_fetch;
            if (stop_fetch && !stop_q) begin
                stop_pkts <= int'(if_valid);   // First stop cycle counts too
            end else if (if_valid && stop_q) begin
                stop_pkts <= stop_pkts + 1;
            end
            if (if_valid) begin
                redirect_pkts <= redirect_pkts + 1;
                expect_base   <= (expect_base & ~32'hf) + 32'd16;
                exc_done      <= expect_exc;
            end
            if (flush || exc_occur) begin
                redirect_pkts <= 0;
                expect_base   <= redirect_target;
                expect_exc    <= redirect_target[1:0] != 2'b00;
                halted        <= redirect_target[1:0] != 2'b00;
                exc_done      <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    assert property (@(posedge clk) disable iff (!rst_n) if_valid |-> if_base_pc == expect_base)
        else note_mismatch($sformatf("base pc %h, expected %h",
            $sampled(if_base_pc), $sampled(expect_base)));

    assert property (@(posedge clk) disable iff (!rst_n) if_valid |-> if_has_exc == expect_exc)
        else note_mismatch($sformatf("exception flag %b, expected %b",
            $sampled(if_has_exc), $sampled(expect_exc)));

    assert property (@(posedge clk) disable iff (!rst_n) if_valid && if_has_exc
        |-> if_exc_code == EXC_ADEL)
        else note_mismatch($sformatf("exception code %0d", $sampled(if_exc_code)));

    assert property (@(posedge clk) disable iff (!rst_n) if_valid |-> !exc_done)
        else note_mismatch("packet after an exception packet");

    assert property (@(posedge clk) disable iff (!rst_n) if_valid && !if_has_exc
        |-> if_enable == enable_for(expect_base) && if_num == num_for(expect_base))
        else note_mismatch($sformatf("enable %b count %0d at base %h",
            $sampled(if_enable), $sampled(if_num), $sampled(expect_base)));

    assert property (@(posedge clk) disable iff (!rst_n) if_valid && !if_has_exc
        |-> if_inst == line_for(expect_base))
        else note_mismatch($sformatf("words %h at base %h",
            $sampled(if_inst), $sampled(expect_base)));

    assert property (@(posedge clk) disable iff (!rst_n) halted |-> !inst_req)
        else note_mismatch("request while halted on an exception");

    assert property (@(posedge clk) disable iff (!rst_n) stop_fetch |-> !(inst_req && index_ok))
        else note_mismatch("request accepted during stop-fetch");

    assert property (@(posedge clk) disable iff (!rst_n) stop_q && if_valid
        |-> stop_pkts < OUTSTANDING)
        else note_mismatch("too many packets after stop-fetch");

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic note_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %0d failed checks", test_num, name, err_count - err_mark);
        test_num++;
        err_mark = err_count;
    endtask

    // Holds the redirect for one cycle
    task automatic redirect(input logic use_flush, input vaddr_t f_target,
                            input logic use_exc, input vaddr_t e_target);
        @(posedge clk);
        flush        <= use_flush;
        flush_target <= f_target;
        exc_occur    <= use_exc;
        exc_target   <= e_target;
        @(posedge clk);
        flush     <= 1'b0;
        exc_occur <= 1'b0;
    endtask

    task automatic wait_packets(input int n);
        int waited;
        waited = 0;
        while (redirect_pkts < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (redirect_pkts < n) begin
            $display("timeout at %0t: %0d of %0d packets arrived", $time, redirect_pkts, n);
            err_count++;
        end
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(inst_req && index_ok) && waited < WAIT_LIMIT);
        if (!(inst_req && index_ok)) begin
            $display("timeout at %0t: no request was accepted by the cache", $time);
            err_count++;
        end
    endtask

    initial begin
        rst_n        <= 1'b0;
        stop_fetch   <= 1'b0;
        flush        <= 1'b0;
        flush_target <= '0;
        exc_occur    <= 1'b0;
        exc_target   <= '0;
        err_count = 0;
        err_mark  = 0;
        test_num  = 1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        wait_packets(6);
        finish_test("sequential fetch");

        redirect(1'b1, 32'h8000_1008, 1'b0, '0);
        wait_packets(3);
        finish_test("unaligned redirect");

        wait_accept();      // Something is in flight when the flush hits
        redirect(1'b1, 32'h8000_2000, 1'b0, '0);
        wait_packets(3);
        finish_test("flush cancels in-flight fetches");

        redirect(1'b1, 32'h8000_3002, 1'b0, '0);
        wait_packets(1);
        repeat (12) @(negedge clk);
        finish_test("misaligned exception");

        redirect(1'b1, 32'h8000_4000, 1'b1, 32'h8000_5004);
        wait_packets(2);
        finish_test("redirect priority");

        wait_accept();
        @(posedge clk);
        stop_fetch <= 1'b1;
        repeat (20) @(negedge clk);
        @(posedge clk);
        stop_fetch <= 1'b0;
        wait_packets(redirect_pkts + 2);
        finish_test("stop-fetch");

        $display("tests run %0d, failed checks %0d", test_num - 1, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/fetch_pkg.sv
rtl/pc_register.sv
rtl/first_cache_trace.sv
rtl/second_cache_trace.sv
rtl/fetch_unit.sv
testbench/inst_cache_model.sv
testbench/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fetch unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_fetch_unit --Mdir "$BUILD_DIR" -o tb_fetch_unit -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_fetch_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG" || ! grep -q ">>> PASS" "$LOG"; then
    exit 1
fi
exit 0
